// File: Bender.yml
package:
  name: qt_queue_core

sources:
  - hw/qt_regs_pkg.sv
  - hw/qt_queue_pkg.sv
  - hw/qt_control_regs.sv
  - hw/qt_queue_table.sv
  - hw/qt_host_port.sv
  - hw/qt_queue_switcher.sv
  - hw/qt_top.sv
  - target: test
    files:
      - dv/qt_clock_gen.sv
      - dv/qt_tb.sv

// File: dv/qt_clock_gen.sv
`timescale 1ns/100ps

module qt_clock_gen (
    output logic pcie_clk,
    output logic pcie_reset_n
);

    // 10 ns period
    initial begin
        pcie_clk = 1'b0;
        forever #5 pcie_clk = ~pcie_clk;
    end

    initial begin
        pcie_reset_n = 1'b0;
        repeat (5) @(posedge pcie_clk);
        pcie_reset_n <= 1'b1;
    end

endmodule

// File: dv/qt_stimulus.txt
# CTRL_WR value | CTRL_RD expected | SWITCH new_tail expected_id
# PAGE_WR page mask kmem_hi kmem_lo head tail | PAGE_RD page burst kmem_hi kmem_lo head tail
CTRL_WR 20000101
CTRL_RD 20000101
CTRL_WR 20000100
CTRL_RD 20000100
PAGE_WR 1 6 aaaa0001 bbbb0001 00000011 deadbeef
PAGE_RD 1 0 00000000 bbbb0001 00000011 00000000
PAGE_WR 1 9 aaaa0001 ffffffff ffffffff 12345678
PAGE_RD 1 0 aaaa0001 bbbb0001 00000011 00000000
PAGE_WR 2 f 0000cccc 22220000 00000022 77777777
PAGE_RD 2 0 0000cccc 22220000 00000022 00000000
PAGE_WR 3 e 00000003 33330000 00000033 00000000
PAGE_WR 0 f 00000000 10000000 00000010 00000005
PAGE_RD 0 0 00000000 10000000 00000010 00000000
SWITCH 00000040 1
PAGE_RD 0 0 00000000 10000000 00000010 00000040
SWITCH 00000041 2
SWITCH 00000042 3
SWITCH 00000043 0
PAGE_RD 3 0 00000003 33330000 00000033 00000043
PAGE_RD 1 0 aaaa0001 bbbb0001 00000011 00000041
SWITCH 00000050 1
PAGE_RD 2 2 0000cccc 55550000 00000066 00000042
PAGE_WR 2 4 ffffffff 55550000 ffffffff ffffffff
PAGE_WR 2 2 ffffffff ffffffff 00000066 ffffffff
PAGE_RD 1 1 aaaa0001 bbbb0001 00000077 00000041
PAGE_WR 1 3 00000000 00000000 00000077 00000099
CTRL_WR 08000100
CTRL_RD 08000100
SWITCH 00000060 0
PAGE_RD 1 0 aaaa0001 bbbb0001 00000077 00000060
SWITCH 00000070 0
PAGE_RD 0 0 00000000 10000000 00000010 00000070

// File: dv/qt_tb.sv
`timescale 1ns/100ps

module qt_tb;
    import qt_regs_pkg::*;
    import qt_queue_pkg::*;

    typedef enum logic [2:0] {
        OP_CTRL_WR,
        OP_CTRL_RD,
        OP_PAGE_WR,
        OP_PAGE_RD,
        OP_SWITCH
    } op_e;

    typedef struct packed {
        op_e              kind;
        logic [5:0][31:0] arg;
    } stim_op_t;

    logic                       pcie_clk;
    logic                       pcie_reset_n;
    logic [PCIE_ADDR_WIDTH-1:0] pcie_address;
    logic                       pcie_write;
    logic                       pcie_read;
    logic [HOST_DATA_WIDTH-1:0] pcie_writedata;
    logic [HOST_BE_WIDTH-1:0]   pcie_byteenable;
    qt_entry_t                  pcie_readdata;
    logic                       pcie_readdatavalid;
    status_addr_e               status_addr;
    logic                       status_read;
    logic                       status_write;
    logic [31:0]                status_writedata;
    logic [31:0]                status_readdata;
    logic                       status_readdata_valid;
    logic                       switch_req;
    logic [FIELD_WIDTH-1:0]     new_tail;
    logic                       switch_ack;
    queue_idx_t                 active_id;
    qt_entry_t                  active;
    logic                       disable_pcie;
    logic [RB_SIZE_WIDTH-1:0]   rb_size;

    stim_op_t     ops[$];
    int           cycle_count = 0;
    int           cycle_limit = 0;
    int           burst_left = 0;
    qt_entry_t    read_expect;

    // reference model of the table, the live queue and the control register
    qt_entry_t    table_model [QUEUE_DEPTH];
    qt_entry_t    active_model;
    queue_idx_t   active_id_model;
    control_reg_t ctrl_model;

    qt_clock_gen u_clock_gen (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n)
    );

    qt_top u_dut (
        .pcie_clk              (pcie_clk),
        .pcie_reset_n          (pcie_reset_n),
        .pcie_address          (pcie_address),
        .pcie_write            (pcie_write),
        .pcie_read             (pcie_read),
        .pcie_writedata        (pcie_writedata),
        .pcie_byteenable       (pcie_byteenable),
        .pcie_readdata         (pcie_readdata),
        .pcie_readdatavalid    (pcie_readdatavalid),
        .status_addr           (status_addr),
        .status_read           (status_read),
        .status_write          (status_write),
        .status_writedata      (status_writedata),
        .status_readdata       (status_readdata),
        .status_readdata_valid (status_readdata_valid),
        .switch_req            (switch_req),
        .new_tail              (new_tail),
        .switch_ack            (switch_ack),
        .active_id             (active_id),
        .active                (active),
        .disable_pcie          (disable_pcie),
        .rb_size               (rb_size)
    );

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic compare_ctrl(string name, control_reg_t got, control_reg_t exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_entry(string name, qt_entry_t got, qt_entry_t exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_id(string name, queue_idx_t got, queue_idx_t exp);
        if (got !== exp) begin
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // round robin over nb_queues that stays on queue 0 with at most one queue
    function automatic queue_idx_t next_queue(queue_idx_t id, logic [NB_QUEUES_WIDTH-1:0] nb);
        if (nb <= 1 || id >= nb - 1) begin
            return '0;
        end
        return id + 1'b1;
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          n;
        int          nargs;
        string       op;
        string       rest;
        logic [31:0] val;
        stim_op_t    s;
        fd = $fopen("dv/qt_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dv/qt_stimulus.txt");
            abort_run();
        end
        while ($fscanf(fd, "%s", op) == 1) begin
            s = '0;
            nargs = 0;
            case (op)
                "CTRL_WR": begin
                    s.kind = OP_CTRL_WR;
                    nargs = 1;
                end
                "CTRL_RD": begin
                    s.kind = OP_CTRL_RD;
                    nargs = 1;
                end
                "PAGE_WR": begin
                    s.kind = OP_PAGE_WR;
                    nargs = 6;
                end
                "PAGE_RD": begin
                    s.kind = OP_PAGE_RD;
                    nargs = 6;
                end
                "SWITCH": begin
                    s.kind = OP_SWITCH;
                    nargs = 2;
                end
                default: begin
                    if (op.substr(0, 0) != "#") begin
                        $display("unknown opcode %s in the stimulus file", op);
                        abort_run();
                    end
                    n = $fgets(rest, fd);
                end
            endcase
            for (int i = 0; i < nargs; i++) begin
                n = $fscanf(fd, "%h", val);
                if (n != 1) begin
                    $display("missing operand for %s in the stimulus file", op);
                    abort_run();
                end
                s.arg[i] = val;
            end
            if (nargs > 0) begin
                ops.push_back(s);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_active();
        compare_entry("active", active, active_model);
        compare_id("active_id", active_id, active_id_model);
    endtask

    task automatic ctrl_write(logic [31:0] value);
        control_reg_t seen;
        @(posedge pcie_clk);
        status_addr <= STATUS_CONTROL;
        status_writedata <= value;
        status_write <= 1'b1;
        @(posedge pcie_clk);
        status_write <= 1'b0;
        ctrl_model = control_reg_t'(value);
        @(negedge pcie_clk);
        seen = ctrl_model;
        seen.rb_size = rb_size;
        seen.disable_pcie = disable_pcie;
        compare_ctrl("rb_size/disable_pcie", seen, ctrl_model);
    endtask

    task automatic ctrl_read(logic [31:0] expected);
        @(posedge pcie_clk);
        status_addr <= STATUS_CONTROL;
        status_read <= 1'b1;
        @(posedge pcie_clk);
        status_read <= 1'b0;
        do @(negedge pcie_clk); while (!status_readdata_valid);
        compare_ctrl("status_readdata", control_reg_t'(status_readdata),
                     control_reg_t'(expected));
    endtask

    task automatic finish_read();
        do @(negedge pcie_clk); while (!pcie_readdatavalid);
        compare_entry("pcie_readdata", pcie_readdata, read_expect);
    endtask

    task automatic page_write(queue_idx_t page, qt_field_we_t mask, qt_entry_t data);
        logic [PCIE_ADDR_WIDTH-1:0] addr;
        logic [HOST_BE_WIDTH-1:0]   be;
        addr = '0;
        addr[PAGE_LSB +: QUEUE_IDX_WIDTH] = page;
        for (int f = 0; f < NUM_FIELDS; f++) begin
            be[f*DWORD_BYTES +: DWORD_BYTES] = {DWORD_BYTES{mask[f]}};
            if (mask[f]) begin
                // tail only reaches the table on a switch
                if (f != int'(FIELD_TAIL)) begin
                    table_model[page][f*FIELD_WIDTH +: FIELD_WIDTH] =
                        data[f*FIELD_WIDTH +: FIELD_WIDTH];
                end
                if (page == active_id_model) begin
                    active_model[f*FIELD_WIDTH +: FIELD_WIDTH] =
                        data[f*FIELD_WIDTH +: FIELD_WIDTH];
                end
            end
        end
        @(posedge pcie_clk);
        pcie_address <= addr;
        pcie_writedata <= data;
        pcie_byteenable <= be;
        pcie_write <= 1'b1;
        pcie_read <= 1'b0;
        if (burst_left > 0) begin
            burst_left--;
            if (burst_left == 0) begin
                @(posedge pcie_clk);
                pcie_write <= 1'b0;
                finish_read();
                check_active();
            end
        end else begin
            @(posedge pcie_clk);
            pcie_write <= 1'b0;
            @(negedge pcie_clk);
            check_active();
        end
    endtask

    // burst > 0 lets that many page writes follow on the very next cycles
    task automatic page_read(queue_idx_t page, int burst, qt_entry_t expected);
        logic [PCIE_ADDR_WIDTH-1:0] addr;
        addr = '0;
        addr[PAGE_LSB +: QUEUE_IDX_WIDTH] = page;
        read_expect = expected;
        @(posedge pcie_clk);
        pcie_address <= addr;
        pcie_read <= 1'b1;
        pcie_write <= 1'b0;
        if (burst == 0) begin
            @(posedge pcie_clk);
            pcie_read <= 1'b0;
            finish_read();
        end else begin
            burst_left = burst;
        end
    endtask

    task automatic do_switch(logic [31:0] tail_val, queue_idx_t exp_id);
        queue_idx_t next;
        next = next_queue(active_id_model, ctrl_model.nb_queues);
        table_model[active_id_model].tail = tail_val;
        active_model = table_model[next];
        if (ctrl_model.nb_queues <= 1) begin
            active_model.tail = tail_val;
        end
        active_id_model = next;
        @(posedge pcie_clk);
        new_tail <= tail_val;
        switch_req <= 1'b1;
        do @(negedge pcie_clk); while (!switch_ack);
        compare_id("active_id", active_id, exp_id);
        compare_entry("active", active, active_model);
        @(posedge pcie_clk);
        switch_req <= 1'b0;
        do @(negedge pcie_clk); while (switch_ack);
    endtask

    task automatic run_op(stim_op_t s);
        qt_entry_t entry;
        entry = qt_entry_t'({s.arg[2], s.arg[3], s.arg[4], s.arg[5]});
        case (s.kind)
            OP_CTRL_WR: ctrl_write(s.arg[0]);
            OP_CTRL_RD: ctrl_read(s.arg[0]);
            OP_PAGE_WR: page_write(s.arg[0][3:0], s.arg[1][3:0], entry);
            OP_PAGE_RD: page_read(s.arg[0][3:0], int'(s.arg[1]), entry);
            default: do_switch(s.arg[0], s.arg[1][3:0]);
        endcase
    endtask

    always @(posedge pcie_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        pcie_address <= '0;
        pcie_write <= 1'b0;
        pcie_read <= 1'b0;
        pcie_writedata <= '0;
        pcie_byteenable <= '0;
        status_addr <= STATUS_CONTROL;
        status_read <= 1'b0;
        status_write <= 1'b0;
        status_writedata <= '0;
        switch_req <= 1'b0;
        new_tail <= '0;
        for (int q = 0; q < QUEUE_DEPTH; q++) begin
            table_model[q] = '0;
        end
        active_model = '0;
        active_id_model = '0;
        ctrl_model = '0;
        load_stimulus();
        cycle_limit = 40 * ops.size();
        wait (pcie_reset_n === 1'b1);
        for (int i = 0; i < ops.size(); i++) begin
            run_op(ops[i]);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: hw/qt_control_regs.sv
`timescale 1ns/100ps

module qt_control_regs (
    input  logic                      pcie_clk,
    input  logic                      pcie_reset_n,
    input  qt_regs_pkg::status_addr_e status_addr,
    input  logic                      status_read,
    input  logic                      status_write,
    input  logic [31:0]               status_writedata,
    output logic [31:0]               status_readdata,
    output logic                      status_readdata_valid,
    output qt_regs_pkg::control_reg_t ctrl
);
    import qt_regs_pkg::*;

    logic ctrl_sel;

    assign ctrl_sel = (status_addr == STATUS_CONTROL);

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            ctrl <= '0;
            status_readdata_valid <= 1'b0;
        end else begin
            status_readdata_valid <= status_read;
            if (status_write && ctrl_sel) begin
                ctrl <= control_reg_t'(status_writedata);
            end
        end
    end

    // a read in the same cycle as a write returns the old value
    always_ff @(posedge pcie_clk) begin
        if (status_read) begin
            status_readdata <= ctrl_sel ? ctrl : '0;
        end
    end

endmodule

// File: hw/qt_host_port.sv
`timescale 1ns/100ps

module qt_host_port (
    input  logic                                    pcie_clk,
    input  logic                                    pcie_reset_n,
    input  logic [qt_regs_pkg::PCIE_ADDR_WIDTH-1:0] pcie_address,
    input  logic                                    pcie_write,
    input  logic                                    pcie_read,
    input  logic [qt_regs_pkg::HOST_DATA_WIDTH-1:0] pcie_writedata,
    input  logic [qt_regs_pkg::HOST_BE_WIDTH-1:0]   pcie_byteenable,
    output qt_queue_pkg::qt_entry_t                 pcie_readdata,
    output logic                                    pcie_readdatavalid,
    output qt_queue_pkg::queue_idx_t                b_addr,
    output qt_queue_pkg::qt_field_we_t              b_we,
    output qt_queue_pkg::qt_entry_t                 b_wdata,
    output logic                                    b_rd,
    input  qt_queue_pkg::qt_entry_t                 b_rdata,
    output qt_queue_pkg::host_update_t              host_update
);
    import qt_regs_pkg::*;
    import qt_queue_pkg::*;

    queue_idx_t   page_idx;
    qt_field_we_t field_we;
    qt_entry_t    wr_entry;
    logic         rd_pending;
    queue_idx_t   rd_page;
    logic         rd_q1;
    logic         rd_q2;

    // page index starts at bit 12 of the host address
    assign page_idx = pcie_address[PAGE_LSB +: QUEUE_IDX_WIDTH];
    assign wr_entry = qt_entry_t'(pcie_writedata);

    // a field counts only with all four of its byte enables
    always_comb begin
        for (int f = 0; f < NUM_FIELDS; f++) begin
            field_we[f] = &pcie_byteenable[f*DWORD_BYTES +: DWORD_BYTES];
        end
    end

    // writes own port b, the pending read goes in the first free cycle
    always_comb begin
        b_we = '0;
        b_addr = rd_page;
        if (pcie_write) begin
            b_we = field_we;
            // tail lives in the switcher until the next queue switch
            b_we[FIELD_TAIL] = 1'b0;
            b_addr = page_idx;
        end
    end

    assign b_wdata = wr_entry;
    assign b_rd = rd_pending & ~pcie_write;

    assign host_update = '{valid: pcie_write, page: page_idx, we: field_we, data: wr_entry};

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            rd_pending <= 1'b0;
            rd_q1 <= 1'b0;
            rd_q2 <= 1'b0;
            pcie_readdatavalid <= 1'b0;
        end else begin
            if (b_rd) begin
                rd_pending <= 1'b0;
            end
            if (pcie_read) begin
                rd_pending <= 1'b1;
            end
            // follow the read through the two table stages
            rd_q1 <= b_rd;
            rd_q2 <= rd_q1;
            pcie_readdatavalid <= rd_q2;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (pcie_read) begin
            rd_page <= page_idx;
        end
        if (rd_q2) begin
            pcie_readdata <= b_rdata;
        end
    end

endmodule

// File: hw/qt_queue_pkg.sv
package qt_queue_pkg;

    localparam int QUEUE_IDX_WIDTH = 4;
    localparam int QUEUE_DEPTH = 1 << QUEUE_IDX_WIDTH;

    // pointers and address halves are all one dword wide
    localparam int FIELD_WIDTH = 32;
    localparam int NUM_FIELDS = 4;

    typedef logic [QUEUE_IDX_WIDTH-1:0] queue_idx_t;

    // same layout as the host read data, tail in dword 0
    typedef struct packed {
        logic [FIELD_WIDTH-1:0] kmem_addr_hi;
        logic [FIELD_WIDTH-1:0] kmem_addr_lo;
        logic [FIELD_WIDTH-1:0] head;
        logic [FIELD_WIDTH-1:0] tail;
    } qt_entry_t;

    typedef enum logic [1:0] {
        FIELD_TAIL    = 2'd0,
        FIELD_HEAD    = 2'd1,
        FIELD_KMEM_LO = 2'd2,
        FIELD_KMEM_HI = 2'd3
    } qt_field_e;

    typedef logic [NUM_FIELDS-1:0] qt_field_we_t;

    typedef enum logic [2:0] {
        SW_IDLE,
        SW_BRAM_DELAY_1,
        SW_BRAM_DELAY_2,
        SW_SWITCH,
        SW_ACK_HOLD
    } switch_state_e;

    // host write as seen by the switcher
    typedef struct packed {
        logic         valid;
        queue_idx_t   page;
        qt_field_we_t we;
        qt_entry_t    data;
    } host_update_t;

endpackage

// File: hw/qt_queue_switcher.sv
`timescale 1ns/100ps

module qt_queue_switcher (
    input  logic                                pcie_clk,
    input  logic                                pcie_reset_n,
    input  qt_regs_pkg::control_reg_t           ctrl,
    input  qt_queue_pkg::host_update_t          host_update,
    input  logic                                switch_req,
    input  logic [qt_queue_pkg::FIELD_WIDTH-1:0] new_tail,
    output logic                                switch_ack,
    output qt_queue_pkg::queue_idx_t            active_id,
    output qt_queue_pkg::qt_entry_t             active,
    output qt_queue_pkg::queue_idx_t            a_addr,
    output qt_queue_pkg::qt_field_we_t          a_we,
    output qt_queue_pkg::qt_entry_t             a_wdata,
    output logic                                a_rd,
    input  qt_queue_pkg::qt_entry_t             a_rdata
);
    import qt_regs_pkg::*;
    import qt_queue_pkg::*;

    switch_state_e              state;
    queue_idx_t                 next_id;
    logic                       multi_queue;
    logic [NB_QUEUES_WIDTH-1:0] last_id;

    assign multi_queue = (ctrl.nb_queues > 1);
    assign last_id = ctrl.nb_queues - 1'b1;

    // round robin, pinned to queue 0 with a single queue
    assign next_id = (!multi_queue || {1'b0, active_id} >= last_id) ? '0 : active_id + 1'b1;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            state <= SW_IDLE;
            switch_ack <= 1'b0;
            active_id <= '0;
            active <= '0;
            a_we <= '0;
            a_rd <= 1'b0;
        end else begin
            a_rd <= 1'b0;
            a_we <= '0;

            // host writes to the active page go straight to the live copy
            if (host_update.valid && host_update.page == active_id) begin
                for (int f = 0; f < NUM_FIELDS; f++) begin
                    if (host_update.we[f]) begin
                        active[f*FIELD_WIDTH +: FIELD_WIDTH] <=
                            host_update.data[f*FIELD_WIDTH +: FIELD_WIDTH];
                    end
                end
            end

            case (state)
                SW_IDLE: begin
                    // fetch the next queue while keeping the finished tail
                    if (switch_req) begin
                        a_addr <= next_id;
                        a_rd <= 1'b1;
                        active.tail <= new_tail;
                        state <= SW_BRAM_DELAY_1;
                    end
                end
                SW_BRAM_DELAY_1: begin
                    state <= SW_BRAM_DELAY_2;
                end
                SW_BRAM_DELAY_2: begin
                    state <= SW_SWITCH;
                end
                SW_SWITCH: begin
                    // save the old tail, new queue and ack show up together
                    a_addr <= active_id;
                    a_we[FIELD_TAIL] <= 1'b1;
                    a_wdata <= '{tail: active.tail, default: '0};
                    if (multi_queue) begin
                        active.tail <= a_rdata.tail;
                    end
                    active.head <= a_rdata.head;
                    active.kmem_addr_lo <= a_rdata.kmem_addr_lo;
                    active.kmem_addr_hi <= a_rdata.kmem_addr_hi;
                    active_id <= next_id;
                    switch_ack <= 1'b1;
                    state <= SW_ACK_HOLD;
                end
                SW_ACK_HOLD: begin
                    if (!switch_req) begin
                        switch_ack <= 1'b0;
                        state <= SW_IDLE;
                    end
                end
                default: begin
                    state <= SW_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/qt_queue_table.sv
`timescale 1ns/100ps

module qt_queue_table (
    input  logic                       pcie_clk,
    input  qt_queue_pkg::queue_idx_t   a_addr,
    input  qt_queue_pkg::queue_idx_t   b_addr,
    input  qt_queue_pkg::qt_field_we_t a_we,
    input  qt_queue_pkg::qt_field_we_t b_we,
    input  qt_queue_pkg::qt_entry_t    a_wdata,
    input  qt_queue_pkg::qt_entry_t    b_wdata,
    input  logic                       a_rd,
    input  logic                       b_rd,
    output qt_queue_pkg::qt_entry_t    a_rdata,
    output qt_queue_pkg::qt_entry_t    b_rdata
);
    import qt_queue_pkg::*;

    qt_entry_t mem [QUEUE_DEPTH] = '{default: '0};

    // two output stages per port
    qt_entry_t a_q1;
    qt_entry_t a_q2;
    qt_entry_t b_q1;
    qt_entry_t b_q2;

    always_ff @(posedge pcie_clk) begin
        // the ports are expected to own disjoint fields
        for (int f = 0; f < NUM_FIELDS; f++) begin
            if (a_we[f]) begin
                mem[a_addr][f*FIELD_WIDTH +: FIELD_WIDTH] <= a_wdata[f*FIELD_WIDTH +: FIELD_WIDTH];
            end
            if (b_we[f]) begin
                mem[b_addr][f*FIELD_WIDTH +: FIELD_WIDTH] <= b_wdata[f*FIELD_WIDTH +: FIELD_WIDTH];
            end
        end

        if (a_rd) begin
            a_q1 <= mem[a_addr];
        end
        if (b_rd) begin
            b_q1 <= mem[b_addr];
        end
        a_q2 <= a_q1;
        b_q2 <= b_q1;
    end

    assign a_rdata = a_q2;
    assign b_rdata = b_q2;

endmodule

// File: hw/qt_regs_pkg.sv
package qt_regs_pkg;

    // host side, one 4 KiB page per queue
    localparam int PCIE_ADDR_WIDTH = 16;
    localparam int PAGE_LSB = 12;

    // only the first four dwords of a page carry queue state
    localparam int HOST_DATA_WIDTH = 128;
    localparam int HOST_BE_WIDTH = HOST_DATA_WIDTH / 8;
    localparam int DWORD_BYTES = 4;

    // status bus
    localparam int STATUS_ADDR_WIDTH = 8;

    // control register field widths
    localparam int NB_QUEUES_WIDTH = 5;
    localparam int RB_SIZE_WIDTH = 26;

    typedef struct packed {
        logic [NB_QUEUES_WIDTH-1:0] nb_queues;
        logic [RB_SIZE_WIDTH-1:0]   rb_size;
        logic                       disable_pcie;
    } control_reg_t;

    // anything else on the status bus reads as zero
    typedef enum logic [STATUS_ADDR_WIDTH-1:0] {
        STATUS_CONTROL = '0
    } status_addr_e;

endpackage

// File: hw/qt_top.sv
`timescale 1ns/100ps

module qt_top (
    input  logic                                    pcie_clk,
    input  logic                                    pcie_reset_n,
    // host port
    input  logic [qt_regs_pkg::PCIE_ADDR_WIDTH-1:0] pcie_address,
    input  logic                                    pcie_write,
    input  logic                                    pcie_read,
    input  logic [qt_regs_pkg::HOST_DATA_WIDTH-1:0] pcie_writedata,
    input  logic [qt_regs_pkg::HOST_BE_WIDTH-1:0]   pcie_byteenable,
    output qt_queue_pkg::qt_entry_t                 pcie_readdata,
    output logic                                    pcie_readdatavalid,
    // status bus
    input  qt_regs_pkg::status_addr_e               status_addr,
    input  logic                                    status_read,
    input  logic                                    status_write,
    input  logic [31:0]                             status_writedata,
    output logic [31:0]                             status_readdata,
    output logic                                    status_readdata_valid,
    // dma engine side
    input  logic                                    switch_req,
    input  logic [qt_queue_pkg::FIELD_WIDTH-1:0]    new_tail,
    output logic                                    switch_ack,
    output qt_queue_pkg::queue_idx_t                active_id,
    output qt_queue_pkg::qt_entry_t                 active,
    output logic                                    disable_pcie,
    output logic [qt_regs_pkg::RB_SIZE_WIDTH-1:0]   rb_size
);
    import qt_regs_pkg::*;
    import qt_queue_pkg::*;

    control_reg_t ctrl;
    host_update_t host_update;
    queue_idx_t   a_addr;
    queue_idx_t   b_addr;
    qt_field_we_t a_we;
    qt_field_we_t b_we;
    qt_entry_t    a_wdata;
    qt_entry_t    b_wdata;
    qt_entry_t    a_rdata;
    qt_entry_t    b_rdata;
    logic         a_rd;
    logic         b_rd;

    assign disable_pcie = ctrl.disable_pcie;
    assign rb_size = ctrl.rb_size;

    qt_control_regs u_control_regs (
        .pcie_clk              (pcie_clk),
        .pcie_reset_n          (pcie_reset_n),
        .status_addr           (status_addr),
        .status_read           (status_read),
        .status_write          (status_write),
        .status_writedata      (status_writedata),
        .status_readdata       (status_readdata),
        .status_readdata_valid (status_readdata_valid),
        .ctrl                  (ctrl)
    );

    qt_queue_table u_queue_table (
        .pcie_clk (pcie_clk),
        .a_addr   (a_addr),
        .b_addr   (b_addr),
        .a_we     (a_we),
        .b_we     (b_we),
        .a_wdata  (a_wdata),
        .b_wdata  (b_wdata),
        .a_rd     (a_rd),
        .b_rd     (b_rd),
        .a_rdata  (a_rdata),
        .b_rdata  (b_rdata)
    );

    qt_host_port u_host_port (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .pcie_address       (pcie_address),
        .pcie_write         (pcie_write),
        .pcie_read          (pcie_read),
        .pcie_writedata     (pcie_writedata),
        .pcie_byteenable    (pcie_byteenable),
        .pcie_readdata      (pcie_readdata),
        .pcie_readdatavalid (pcie_readdatavalid),
        .b_addr             (b_addr),
        .b_we               (b_we),
        .b_wdata            (b_wdata),
        .b_rd               (b_rd),
        .b_rdata            (b_rdata),
        .host_update        (host_update)
    );

    qt_queue_switcher u_queue_switcher (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .ctrl         (ctrl),
        .host_update  (host_update),
        .switch_req   (switch_req),
        .new_tail     (new_tail),
        .switch_ack   (switch_ack),
        .active_id    (active_id),
        .active       (active),
        .a_addr       (a_addr),
        .a_we         (a_we),
        .a_wdata      (a_wdata),
        .a_rd         (a_rd),
        .a_rdata      (a_rdata)
    );

endmodule

// File: verilog.f
hw/qt_regs_pkg.sv
hw/qt_queue_pkg.sv
hw/qt_control_regs.sv
hw/qt_queue_table.sv
hw/qt_host_port.sv
hw/qt_queue_switcher.sv
hw/qt_top.sv
dv/qt_clock_gen.sv
dv/qt_tb.sv
